/* Makefile */
# Verilator flow for the write-strength unit
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module dnc_write_strength

sim:
	verilator --binary --timing -f sim.f --top-module dnc_write_strength_tb -o simv
	./obj_dir/simv > $(LOG)
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/dnc_write_strength.sv */
/*
  beta = oneplus(beta_in) = 1 + ln(1 + e^beta_in), Q8.8 in and out.
  One value at a time: pulse start while ready, result 20 cycles later.
*/

`timescale 1ns/1ps

module dnc_write_strength (
  // Global
  input  logic        clk,
  input  logic        reset,

  // Control
  input  logic        start,
  output logic        ready,

  // Data
  input  logic [15:0] beta_in,
  output logic [15:0] beta_out
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Sequencer and counter
  write_strength_pkg::phase_t phase;
  logic count_enable;
  logic count_clear;
  logic count_last;
  logic [2:0] count_index;

  // Data path
  write_strength_pkg::exponent_word_t exponent;
  logic [write_strength_pkg::acc_width-1:0] z;
  logic [write_strength_pkg::data_width-1:0] log2_word;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  oneplus_sequencer oneplus_sequencer_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .count_last   (count_last),
    .phase        (phase),
    .count_enable (count_enable),
    .count_clear  (count_clear),
    .ready        (ready)
  );

  iteration_counter iteration_counter_i (
    .clk          (clk),
    .reset        (reset),
    .count_enable (count_enable),
    .count_clear  (count_clear),
    .count_index  (count_index),
    .count_last   (count_last)
  );

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  // Clamp and scale in, ln 2 and +1.0 out
  fixed_scaler fixed_scaler_i (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .beta_in   (beta_in),
    .log2_word (log2_word),
    .exponent  (exponent),
    .beta_out  (beta_out)
  );

  exp2_unit exp2_unit_i (
    .clk         (clk),
    .reset       (reset),
    .phase       (phase),
    .count_index (count_index),
    .exponent    (exponent),
    .z           (z)
  );

  log2_unit log2_unit_i (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .z         (z),
    .log2_word (log2_word)
  );

endmodule

/* logic/exp2_unit.sv */
/*
  Forms z = 1 + 2^t in Q16.16. Products truncate toward zero.
  Assumes int_part within -12 to 11, which the input clamp guarantees.
*/

`timescale 1ns/1ps

module exp2_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  write_strength_pkg::phase_t          phase,
  input  logic [2:0]                          count_index,
  input  write_strength_pkg::exponent_word_t  exponent,
  output logic [write_strength_pkg::acc_width-1:0] z
);

  // Running product of 2^fraction
  logic [write_strength_pkg::acc_width-1:0] p;
  logic [2*write_strength_pkg::acc_width-1:0] root_product;
  logic [write_strength_pkg::acc_width-1:0] shifted;
  logic signed [7:0] int_part;
  logic [7:0] shift_amount;
  logic frac_bit;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  assign int_part = exponent.split.int_part;

  // Fraction bits are taken MSB first
  assign frac_bit = exponent.split.frac_part[3'd7 - count_index];

  // Wide product, p stays below 2.0
  assign root_product = p * write_strength_pkg::exp2_root_table[count_index];

  // Signed shift by the integer part
  always_comb begin
    if (int_part >= 0) begin
      shift_amount = int_part;
      shifted = p << shift_amount;
    end else begin
      shift_amount = -int_part;
      shifted = p >> shift_amount;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      p <= write_strength_pkg::one_q16;
      z <= write_strength_pkg::one_q16;
    end else begin
      case (phase)
        write_strength_pkg::scale: p <= write_strength_pkg::one_q16;
        write_strength_pkg::exp_iter: begin
          if (frac_bit) begin
            p <= root_product[47:16];
          end
        end
        // Adds the 1.0 of 1 + 2^t
        write_strength_pkg::exp_shift: z <= shifted + write_strength_pkg::one_q16;
        default: ;
      endcase
    end
  end

endmodule

/* logic/fixed_scaler.sv */
/*
  One signed multiplier for t = clamp(beta_in) * log2(e) and for ln 2 * log2 + 1.0.
  Both results truncate by an arithmetic shift of 8. beta_out is 0 after reset.
*/

`timescale 1ns/1ps

module fixed_scaler (
  input  logic                                             clk,
  input  logic                                             reset,
  input  write_strength_pkg::phase_t                       phase,
  input  logic signed [write_strength_pkg::data_width-1:0] beta_in,
  input  logic [write_strength_pkg::data_width-1:0]        log2_word,
  output write_strength_pkg::exponent_word_t               exponent,
  output logic [write_strength_pkg::data_width-1:0]        beta_out
);

  logic signed [write_strength_pkg::data_width-1:0] clamped;
  logic signed [write_strength_pkg::data_width-1:0] mul_a;
  logic signed [write_strength_pkg::data_width-1:0] mul_b;
  logic signed [write_strength_pkg::acc_width-1:0] product;
  logic signed [write_strength_pkg::acc_width-1:0] scaled;

  // Input limited to [-8, 8)
  always_comb begin
    if (beta_in < write_strength_pkg::clamp_lo) begin
      clamped = write_strength_pkg::clamp_lo;
    end else if (beta_in > write_strength_pkg::clamp_hi) begin
      clamped = write_strength_pkg::clamp_hi;
    end else begin
      clamped = beta_in;
    end
  end

  // Operands switch over in finish where log2_word is never negative
  assign mul_a = (phase == write_strength_pkg::finish) ? signed'(log2_word) : clamped;
  assign mul_b = (phase == write_strength_pkg::finish) ? write_strength_pkg::ln2_q8
                                                       : write_strength_pkg::log2e_q8;

  assign product = mul_a * mul_b;
  assign scaled = product >>> write_strength_pkg::frac_bits;

  // Scaled exponent t captured in the scale phase
  always_ff @(posedge clk) begin
    if (phase == write_strength_pkg::scale) begin
      exponent.raw <= scaled[write_strength_pkg::data_width-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      beta_out <= '0;
    end else if (phase == write_strength_pkg::finish) begin
      beta_out <= scaled[write_strength_pkg::data_width-1:0] + write_strength_pkg::one_q8;
    end
  end

endmodule

/* logic/iteration_counter.sv */
/*
  Step index for the bit-serial loops, 0 to 7. Clear wins over enable.
*/

`timescale 1ns/1ps

module iteration_counter (
  input  logic       clk,
  input  logic       reset,
  input  logic       count_enable,
  input  logic       count_clear,
  output logic [2:0] count_index,
  output logic       count_last
);

  // Synchronous clear restarts the loop
  always_ff @(posedge clk) begin
    if (reset) begin
      count_index <= 3'd0;
    end else if (count_clear) begin
      count_index <= 3'd0;
    end else if (count_enable) begin
      count_index <= count_index + 3'd1;
    end
  end

  // High during the eighth step
  assign count_last = (count_index == 3'(write_strength_pkg::iter_count - 1));

endmodule

/* logic/log2_unit.sv */
/*
  log2 of z in Q8.8, z assumed at least 1.0 in Q16.16.
  Alignment and squarings truncate, one fraction bit per log_iter cycle.
*/

`timescale 1ns/1ps

module log2_unit (
  input  logic                                     clk,
  input  logic                                     reset,
  input  write_strength_pkg::phase_t               phase,
  input  logic [write_strength_pkg::acc_width-1:0] z,
  output logic [write_strength_pkg::data_width-1:0] log2_word
);

  // Leading one position of z
  logic [4:0] lead;
  // Integer part of the result
  logic [4:0] e;
  logic [4:0] e_next;
  // Mantissa in [1.0, 2.0)
  logic [write_strength_pkg::acc_width-1:0] m;
  logic [2*write_strength_pkg::acc_width-1:0] square;
  logic [write_strength_pkg::acc_width-1:0] square_q16;
  logic [write_strength_pkg::frac_bits-1:0] fraction;
  logic square_high;

  //////////////////////////////////////////////////
  // Normalization
  //////////////////////////////////////////////////

  // Highest set bit wins
  always_comb begin
    lead = 5'd0;
    for (int i = 0; i < write_strength_pkg::acc_width; i++) begin
      if (z[i]) begin
        lead = 5'(i);
      end
    end
  end

  assign e_next = lead - 5'd16;

  //////////////////////////////////////////////////
  // Squaring step
  //////////////////////////////////////////////////

  assign square = m * m;
  assign square_q16 = square[47:16];
  // Square reached 2.0, so this fraction bit is set
  assign square_high = (square_q16 >= 32'd131072);

  always_ff @(posedge clk) begin
    if (reset) begin
      e <= 5'd0;
      m <= write_strength_pkg::one_q16;
      fraction <= '0;
    end else begin
      case (phase)
        write_strength_pkg::log_norm: begin
          e <= e_next;
          m <= z >> e_next;
          fraction <= '0;
        end
        write_strength_pkg::log_iter: begin
          // Bits enter at the LSB and end up MSB first
          fraction <= {fraction[write_strength_pkg::frac_bits-2:0], square_high};
          if (square_high) begin
            m <= square_q16 >> 1;
          end else begin
            m <= square_q16;
          end
        end
        default: ;
      endcase
    end
  end

  // e * 256 + fraction
  assign log2_word = {3'b000, e, fraction};

endmodule

/* logic/oneplus_sequencer.sv */
/*
  Control FSM for one oneplus evaluation, 20 cycles from start to result.
  A start outside idle is ignored.
*/

`timescale 1ns/1ps

module oneplus_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      count_last,
  output write_strength_pkg::phase_t phase,
  output logic                      count_enable,
  output logic                      count_clear,
  output logic                      ready
);

  write_strength_pkg::phase_t next_phase;

  //////////////////////////////////////////////////
  // Next phase
  //////////////////////////////////////////////////

  always_comb begin
    next_phase = phase;
    case (phase)
      write_strength_pkg::idle: begin
        if (start) begin
          next_phase = write_strength_pkg::scale;
        end
      end
      write_strength_pkg::scale: begin
        next_phase = write_strength_pkg::exp_iter;
      end
      // Eight fraction bits, leave on the last one
      write_strength_pkg::exp_iter: begin
        if (count_last) begin
          next_phase = write_strength_pkg::exp_shift;
        end
      end
      write_strength_pkg::exp_shift: begin
        next_phase = write_strength_pkg::log_norm;
      end
      write_strength_pkg::log_norm: begin
        next_phase = write_strength_pkg::log_iter;
      end
      // Eight squaring steps
      write_strength_pkg::log_iter: begin
        if (count_last) begin
          next_phase = write_strength_pkg::finish;
        end
      end
      write_strength_pkg::finish: begin
        next_phase = write_strength_pkg::idle;
      end
      default: begin
        next_phase = write_strength_pkg::idle;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Counter control
  //////////////////////////////////////////////////

  // Counter runs only in the two iteration phases
  assign count_enable = (phase == write_strength_pkg::exp_iter) ||
                        (phase == write_strength_pkg::log_iter);

  // Zero the index on accept and again between the exp and log loops
  assign count_clear = ((phase == write_strength_pkg::idle) && start) ||
                       ((phase == write_strength_pkg::exp_iter) && count_last);

  //////////////////////////////////////////////////
  // State and ready
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= write_strength_pkg::idle;
      ready <= 1'b1;
    end else begin
      phase <= next_phase;
      // Ready tracks the phase one edge ahead, so it drops with start
      ready <= (next_phase == write_strength_pkg::idle);
    end
  end

endmodule

/* logic/write_strength_pkg.sv */
/*
  Shared formats for the write-strength unit: Q8.8 words in and out, Q16.16 inside.
  Formats are fixed. The root table holds exactly iter_count entries.
*/

package write_strength_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int data_width = 16;
  localparam int frac_bits = 8;
  localparam int acc_width = 32;
  localparam int iter_count = 8;

  //////////////////////////////////////////////////
  // Fixed-point constants
  //////////////////////////////////////////////////

  // Input clamp limits, -8.0 and just under 8.0
  localparam logic signed [data_width-1:0] clamp_lo = -16'sd2048;
  localparam logic signed [data_width-1:0] clamp_hi = 16'sd2047;

  // Scale factors in Q8.8
  localparam logic signed [data_width-1:0] log2e_q8 = 16'sd369;
  localparam logic signed [data_width-1:0] ln2_q8 = 16'sd177;
  localparam logic signed [data_width-1:0] one_q8 = 16'sd256;

  // 1.0 in Q16.16
  localparam logic [acc_width-1:0] one_q16 = 32'd65536;

  // Entry k is 2^(2^-(k+1)) in Q16.16, rounded
  localparam logic [acc_width-1:0] exp2_root_table [0:iter_count-1] = '{
    32'd92682,
    32'd77936,
    32'd71468,
    32'd68438,
    32'd66971,
    32'd66250,
    32'd65892,
    32'd65714
  };

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Scaled exponent t, seen whole or as integer and fraction
  typedef union packed {
    logic signed [data_width-1:0] raw;
    struct packed {
      logic signed [7:0] int_part;
      logic [7:0] frac_part;
    } split;
  } exponent_word_t;

  // Processing phases, in the order they run
  typedef enum logic [2:0] {
    idle,
    scale,
    exp_iter,
    exp_shift,
    log_norm,
    log_iter,
    finish
  } phase_t;

endpackage

/* sim.f */
logic/write_strength_pkg.sv
logic/oneplus_sequencer.sv
logic/iteration_counter.sv
logic/exp2_unit.sv
logic/log2_unit.sv
logic/fixed_scaler.sv
logic/dnc_write_strength.sv
test/write_strength_checker.sv
test/dnc_write_strength_tb.sv

/* test/dnc_write_strength_tb.sv */
/*
  Seeded random operations into the write-strength unit, one at a time.
  beta_in stays put until ready returns. A cycle limit ends a stuck run.
*/

`timescale 1ns/1ps

module dnc_write_strength_tb;

  // Operation mix
  localparam int random_ops = 150;
  localparam int clamp_ops = 32;
  localparam int busy_ops = 10;
  localparam int sweep_ops = 20;
  localparam int op_total = random_ops + clamp_ops + busy_ops + sweep_ops;
  // About 22 cycles per operation plus reset and slack
  localparam int cycle_limit = op_total * 24 + 100;

  // Group codes as the checker names them
  localparam int group_reset = 0;
  localparam int group_random = 1;
  localparam int group_clamp = 2;
  localparam int group_busy = 3;
  localparam int group_sweep = 4;

  logic        clk;
  logic        reset;
  logic        start;
  logic [15:0] beta_in;
  logic        ready;
  logic [15:0] beta_out;
  int          test_group;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          stall_count;
  int          seed;

  //////////////////////////////////////////////////
  // DUT and checker
  //////////////////////////////////////////////////

  dnc_write_strength dnc_write_strength_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .ready    (ready),
    .beta_in  (beta_in),
    .beta_out (beta_out)
  );

  write_strength_checker write_strength_checker_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .beta_in    (beta_in),
    .ready      (ready),
    .beta_out   (beta_out),
    .test_group (test_group),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Hard stop
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run stopped at the %0d cycle limit before all tests finished", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Driving
  //////////////////////////////////////////////////

  // Returns on a falling edge with ready high or after 40 cycles
  task automatic wait_ready();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!ready && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      $display("ready stayed low for 40 cycles");
      stall_count++;
    end
  endtask

  // One operation with an optional stray start mid-computation
  task automatic run_op(input logic [15:0] value, input logic intrude);
    wait_ready();
    start = 1'b1;
    beta_in = value;
    @(negedge clk);
    start = 1'b0;
    if (intrude) begin
      repeat (4) @(negedge clk);
      start = 1'b1;
      beta_in = ~value;
      @(negedge clk);
      start = 1'b0;
    end
    wait_ready();
  endtask

  initial begin
    int          r;
    logic [15:0] value;
    seed = 60795;
    cycle_count = 0;
    stall_count = 0;
    start = 1'b0;
    beta_in = 16'd0;
    test_group = group_reset;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // In range [-8, 8)
    test_group = group_random;
    for (int i = 0; i < random_ops; i++) begin
      value = 16'(($random(seed) & 4095) - 2048);
      run_op(value, 1'b0);
    end

    // Boundaries first and then beyond them either way
    test_group = group_clamp;
    run_op(write_strength_pkg::clamp_lo, 1'b0);
    run_op(write_strength_pkg::clamp_hi, 1'b0);
    for (int i = 0; i < clamp_ops - 2; i++) begin
      r = ($random(seed) & 32'h7fff) % 30720;
      if (($random(seed) & 1) != 0) begin
        value = 16'(2048 + r);
      end else begin
        value = 16'(-2049 - r);
      end
      run_op(value, 1'b0);
    end

    // Stray start with another input while busy
    test_group = group_busy;
    for (int i = 0; i < busy_ops; i++) begin
      value = 16'(($random(seed) & 4095) - 2048);
      run_op(value, 1'b1);
    end

    // Ascending sweep over the whole range
    test_group = group_sweep;
    for (int i = 0; i < sweep_ops; i++) begin
      run_op(16'(-2048 + i * 215), 1'b0);
    end

    // Let the checker judge the last result
    repeat (2) @(negedge clk);
    $display("Tests passed: %0d, failed: %0d, stalls: %0d", pass_count, fail_count,
             stall_count);
    if (pass_count + fail_count != op_total + 1) begin
      $display("Only %0d of %0d tests reported a result", pass_count + fail_count,
               op_total + 1);
    end
    if (fail_count == 0 && stall_count == 0 && pass_count == op_total + 1) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* test/write_strength_checker.sv */
/*
  Bit-exact reference for oneplus, plus latency, lower-bound, clamp and sweep checks.
  Assumes one operation in flight and beta_in held through the cycle after start.
*/

`timescale 1ns/1ps

module write_strength_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [15:0] beta_in,
  input  logic        ready,
  input  logic [15:0] beta_out,
  input  int          test_group,
  output int          pass_count,
  output int          fail_count
);

  // Operation in flight
  logic        busy;
  int          cycles;
  logic [15:0] operand;
  logic [15:0] expected;
  int          op_group;
  int          test_index;
  int          group_counts [0:4];
  logic        prev_reset;

  // DUT results kept for the clamp and sweep comparisons
  logic        lo_seen;
  logic        hi_seen;
  logic        sweep_seen;
  logic [15:0] lo_result;
  logic [15:0] hi_result;
  logic [15:0] sweep_last;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [15:0] oneplus_model(input logic [15:0] x);
    int     clamped;
    int     t;
    int     int_part;
    int     frac;
    int     e;
    int     fraction;
    int     log_word;
    int     result;
    longint p;
    longint z;
    longint m;
    // Clamp to [-8, 8) and scale by log2(e) with floor on the shift
    clamped = int'($signed(x));
    if (clamped < int'(write_strength_pkg::clamp_lo)) begin
      clamped = int'(write_strength_pkg::clamp_lo);
    end else if (clamped > int'(write_strength_pkg::clamp_hi)) begin
      clamped = int'(write_strength_pkg::clamp_hi);
    end
    t = (clamped * int'(write_strength_pkg::log2e_q8)) >>> 8;
    int_part = t >>> 8;
    frac = t & 255;
    // 2^frac as a product of roots taken MSB first
    p = longint'(write_strength_pkg::one_q16);
    for (int k = 0; k < 8; k++) begin
      if (frac[7-k]) begin
        p = (p * longint'(write_strength_pkg::exp2_root_table[k])) >> 16;
      end
    end
    if (int_part >= 0) begin
      z = p << int_part;
    end else begin
      z = p >> (-int_part);
    end
    z = (z + 65536) & 64'hFFFF_FFFF;
    // Integer part of log2 from the leading one
    e = 0;
    while ((z >> (e + 17)) != 0) begin
      e++;
    end
    m = z >> e;
    // One fraction bit per squaring
    fraction = 0;
    for (int k = 0; k < 8; k++) begin
      m = (m * m) >> 16;
      fraction = fraction * 2;
      if (m >= 131072) begin
        fraction = fraction + 1;
        m = m >> 1;
      end
    end
    log_word = e * 256 + fraction;
    result = ((log_word * int'(write_strength_pkg::ln2_q8)) >>> 8) + 256;
    return result[15:0];
  endfunction

  function automatic string group_name(input int code);
    case (code)
      0: return "reset";
      1: return "random";
      2: return "clamp";
      3: return "busy_start";
      default: return "sweep";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Judging one finished operation
  //////////////////////////////////////////////////

  task automatic judge_result(input logic [15:0] actual, input int latency);
    string name;
    logic  beyond_lo;
    logic  beyond_hi;
    name = $sformatf("%s #%0d", group_name(op_group), test_index);
    beyond_lo = $signed(operand) < write_strength_pkg::clamp_lo;
    beyond_hi = $signed(operand) > write_strength_pkg::clamp_hi;
    if (latency != 20) begin
      $display("%s: ready came back after %0d cycles instead of 20", name, latency);
      fail_count++;
    end else if (actual < 16'd256) begin
      $display("%s: result 0x%04h is below 1.0", name, actual);
      fail_count++;
    end else if (op_group == 2 && beyond_lo && lo_seen && actual !== lo_result) begin
      $display("FAILED %s expected 0x%04h actual 0x%04h", name, lo_result, actual);
      fail_count++;
    end else if (op_group == 2 && beyond_hi && hi_seen && actual !== hi_result) begin
      $display("FAILED %s expected 0x%04h actual 0x%04h", name, hi_result, actual);
      fail_count++;
    end else if (op_group == 4 && sweep_seen && actual < sweep_last) begin
      $display("%s: result 0x%04h fell below the previous point 0x%04h", name, actual,
               sweep_last);
      fail_count++;
    end else if (actual !== expected) begin
      $display("FAILED %s expected 0x%04h actual 0x%04h", name, expected, actual);
      fail_count++;
    end else begin
      $display("ok     %s in 0x%04h out 0x%04h", name, operand, actual);
      pass_count++;
    end
    // Boundary results are what later clamped inputs must match
    if (op_group == 2 && $signed(operand) == write_strength_pkg::clamp_lo) begin
      lo_result = actual;
      lo_seen = 1'b1;
    end
    if (op_group == 2 && $signed(operand) == write_strength_pkg::clamp_hi) begin
      hi_result = actual;
      hi_seen = 1'b1;
    end
    if (op_group == 4) begin
      sweep_last = actual;
      sweep_seen = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  // Values read here are the ones held over the cycle that just ended
  always @(posedge clk) begin
    if (reset) begin
      busy = 1'b0;
      lo_seen = 1'b0;
      hi_seen = 1'b0;
      sweep_seen = 1'b0;
      pass_count = 0;
      fail_count = 0;
      for (int g = 0; g < 5; g++) begin
        group_counts[g] = 0;
      end
    end else begin
      // First edge out of reset shows the reset outputs
      if (prev_reset) begin
        if (ready !== 1'b1 || beta_out !== 16'd0) begin
          $display("FAILED reset #0 expected ready 1 out 0x0000 actual ready %b out 0x%04h",
                   ready, beta_out);
          fail_count++;
        end else begin
          $display("ok     reset #0 ready 1 out 0x0000");
          pass_count++;
        end
      end
      if (busy) begin
        cycles++;
        if (ready) begin
          // Ready rose on the edge before this one
          judge_result(beta_out, cycles - 1);
          busy = 1'b0;
        end else if (cycles > 40) begin
          $display("%s #%0d: ready never came back", group_name(op_group), test_index);
          fail_count++;
          busy = 1'b0;
        end
      end
      // Accepted start only while ready
      if (start && ready) begin
        busy = 1'b1;
        cycles = 0;
        operand = beta_in;
        expected = oneplus_model(beta_in);
        op_group = test_group;
        test_index = group_counts[test_group];
        group_counts[test_group]++;
      end
    end
    prev_reset = reset;
  end

endmodule
